//--- include/axis_sw_macros.svh
`ifndef AXIS_SW_MACROS_SVH
`define AXIS_SW_MACROS_SVH

// stream field widths
`define AXIS_DATA_W     32
`define AXIS_USER_W     2
`define AXIS_TID_W      2

// upstream sources: user project, axi-lite bridge, logic analyzer
`define AXIS_NUM_SRC    3

// return path fifo
`define RET_FIFO_DEPTH  16

// threshold register
`define TH_W            4
`define TH_RESET        6

`define AXIL_ADDR_W     15

`endif

//--- hdl/axis_sw_pkg.sv
`include "axis_sw_macros.svh"

package axis_sw_pkg;

    // stream id carried on the serializer side
    typedef logic [`AXIS_TID_W-1:0] axis_tid_t;

    // one beat, no routing information
    typedef struct packed {
        logic [`AXIS_DATA_W-1:0]   data;
        logic [`AXIS_DATA_W/8-1:0] strb;
        logic [`AXIS_DATA_W/8-1:0] keep;
        logic                      last;
        logic [`AXIS_USER_W-1:0]   user;
    } axis_beat_t;

    // beat as seen by the serializer
    typedef struct packed {
        axis_beat_t beat;
        axis_tid_t  tid;
    } axis_tagged_beat_t;

    // one bit per upstream source
    typedef logic [`AXIS_NUM_SRC-1:0] src_vec_t;
    typedef axis_beat_t [`AXIS_NUM_SRC-1:0] src_beats_t;

    typedef logic [`TH_W-1:0] th_t;

    // source ids
    localparam axis_tid_t TID_UP = 2'd0;
    localparam axis_tid_t TID_AA = 2'd1;
    localparam axis_tid_t TID_LA = 2'd2;

endpackage

//--- hdl/axis_sw_cfg_regs.sv
`include "axis_sw_macros.svh"

module axis_sw_cfg_regs
    import axis_sw_pkg::*;
(
    input  logic                    axis_clk,
    input  logic                    axi_reset_n,
    input  logic                    cc_as_enable,
    // write address / data
    input  logic                    axi_awvalid,
    input  logic [`AXIL_ADDR_W-1:0] axi_awaddr,
    output logic                    axi_awready,
    input  logic                    axi_wvalid,
    input  logic [31:0]             axi_wdata,
    input  logic [3:0]              axi_wstrb,
    output logic                    axi_wready,
    // read address / data
    input  logic                    axi_arvalid,
    output logic                    axi_arready,
    output logic                    axi_rvalid,
    output logic [31:0]             axi_rdata,
    input  logic                    axi_rready,
    // fifo threshold
    output th_t                     th
);

    logic wr_go;
    logic wr_hit;
    logic rd_go;

    ////////////////////////////////
    // write side
    ////////////////////////////////

    // address and data are taken together, only while enabled
    assign wr_go       = cc_as_enable && axi_awvalid && axi_wvalid;
    assign axi_awready = wr_go;
    assign axi_wready  = wr_go;

    // word offset 0, low byte lane
    assign wr_hit = (axi_awaddr[`AXIL_ADDR_W-1:2] == '0) && axi_wstrb[0];

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            th <= th_t'(`TH_RESET);
        end else if (wr_go && wr_hit) begin
            th <= axi_wdata[`TH_W-1:0];
        end
    end

    ////////////////////////////////
    // read side
    ////////////////////////////////

    // one response in flight at most
    assign axi_arready = !axi_rvalid;
    assign rd_go       = axi_arvalid && axi_arready;

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            axi_rvalid <= 1'b0;
        end else if (rd_go) begin
            axi_rvalid <= 1'b1;
        end else if (axi_rready) begin
            axi_rvalid <= 1'b0;
        end
    end

    // single register, address not decoded
    always_ff @(posedge axis_clk) begin
        if (rd_go) begin
            axi_rdata <= {{(32-`TH_W){1'b0}}, th};
        end
    end

endmodule

//--- hdl/axis_frame_arbiter.sv
`include "axis_sw_macros.svh"

module axis_frame_arbiter
    import axis_sw_pkg::*;
(
    input  logic              axis_clk,
    input  logic              axi_reset_n,
    // upstream sources, indexed by tid
    input  src_beats_t        src_in,
    input  src_vec_t          src_valid,
    output src_vec_t          src_ready,
    // toward the serializer
    output axis_tagged_beat_t is_out,
    output logic              is_out_valid,
    input  logic              is_out_ready
);

    localparam int NUM_SRC = `AXIS_NUM_SRC;

    axis_tid_t  base_ptr;
    axis_tid_t  base_next;
    src_vec_t   grant;
    src_vec_t   grant_pick;
    logic       frame_active;
    axis_tid_t  grant_tid;
    axis_beat_t sel_beat;
    logic       load_ok;
    logic       accept;

    // one-hot grant to source id
    function automatic axis_tid_t grant_to_tid(input src_vec_t g);
        case (g)
            3'b001:  grant_to_tid = TID_UP;
            3'b010:  grant_to_tid = TID_AA;
            default: grant_to_tid = TID_LA;
        endcase
    endfunction

    ////////////////////////////////
    // rotating priority
    ////////////////////////////////

    // search starts at base_ptr and wraps
    always_comb begin
        int unsigned idx;
        grant_pick = '0;
        for (int unsigned i = 0; i < NUM_SRC; i++) begin
            idx = base_ptr + i;
            if (idx >= NUM_SRC) begin
                idx = idx - NUM_SRC;
            end
            if (grant_pick == '0 && src_valid[idx]) begin
                grant_pick[idx] = 1'b1;
            end
        end
    end

    assign grant_tid = grant_to_tid(grant);
    assign base_next = (grant_tid == axis_tid_t'(NUM_SRC - 1)) ? '0 : grant_tid + 1'b1;

    ////////////////////////////////
    // source handshake
    ////////////////////////////////

    // output register free or draining this cycle
    assign load_ok   = !is_out_valid || is_out_ready;
    assign src_ready = grant & {NUM_SRC{load_ok}};
    assign accept    = |(src_ready & src_valid);
    assign sel_beat  = src_in[grant_tid];

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            base_ptr     <= '0;
            grant        <= '0;
            frame_active <= 1'b0;
        end else if (!frame_active) begin
            // idle cycle, arbitrate
            grant        <= grant_pick;
            frame_active <= |grant_pick;
        end else if (accept && sel_beat.last) begin
            // frame done, next search starts after this source
            grant        <= '0;
            frame_active <= 1'b0;
            base_ptr     <= base_next;
        end
    end

    ////////////////////////////////
    // output register
    ////////////////////////////////

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            is_out_valid <= 1'b0;
        end else if (accept) begin
            is_out_valid <= 1'b1;
        end else if (is_out_ready) begin
            is_out_valid <= 1'b0;
        end
    end

    // holds while stalled since accept needs load_ok
    always_ff @(posedge axis_clk) begin
        if (accept) begin
            is_out.beat <= sel_beat;
            is_out.tid  <= grant_tid;
        end
    end

endmodule

//--- hdl/axis_return_demux.sv
`include "axis_sw_macros.svh"

module axis_return_demux
    import axis_sw_pkg::*;
(
    input  logic              axis_clk,
    input  logic              axi_reset_n,
    input  th_t               th,
    // return stream from the serializer
    input  axis_tagged_beat_t is_in,
    input  logic              is_in_valid,
    output logic              is_in_ready,
    // user project
    output axis_beat_t        up_out,
    output logic              up_out_valid,
    input  logic              up_out_ready,
    // axi-lite bridge
    output axis_beat_t        aa_out,
    output logic              aa_out_valid,
    input  logic              aa_out_ready
);

    localparam int DEPTH = `RET_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    // leave room for the beat that may land while ready is still high
    localparam logic [AW:0] OCC_LIMIT = (AW + 1)'(DEPTH - 2);

    axis_tagged_beat_t mem [DEPTH];
    axis_tagged_beat_t head;

    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] occupancy;
    logic        empty;
    logic        push;
    logic        pop;
    logic        drop;

    ////////////////////////////////
    // fifo storage
    ////////////////////////////////

    assign push      = is_in_valid && is_in_ready;
    assign occupancy = wr_ptr - rd_ptr;
    assign empty     = (wr_ptr == rd_ptr);
    assign head      = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge axis_clk) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= is_in;
        end
    end

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            is_in_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // throttle on last cycle's occupancy
            is_in_ready <= (occupancy <= {1'b0, th}) && (occupancy <= OCC_LIMIT);
        end
    end

    ////////////////////////////////
    // tid routing
    ////////////////////////////////

    // head blocks everything behind it
    assign up_out_valid = !empty && (head.tid == TID_UP);
    assign aa_out_valid = !empty && (head.tid == TID_AA);
    assign up_out       = head.beat;
    assign aa_out       = head.beat;

    // tid 2 and 3 have no destination on this path
    assign drop = !empty && (head.tid != TID_UP) && (head.tid != TID_AA);

    assign pop = (up_out_valid && up_out_ready) || (aa_out_valid && aa_out_ready) || drop;

endmodule

//--- hdl/axis_sw.sv
`include "axis_sw_macros.svh"

module axis_sw
    import axis_sw_pkg::*;
(
    input  logic                    axis_clk,
    input  logic                    axi_reset_n,
    // axi-lite config port
    input  logic                    cc_as_enable,
    input  logic                    axi_awvalid,
    input  logic [`AXIL_ADDR_W-1:0] axi_awaddr,
    output logic                    axi_awready,
    input  logic                    axi_wvalid,
    input  logic [31:0]             axi_wdata,
    input  logic [3:0]              axi_wstrb,
    output logic                    axi_wready,
    input  logic                    axi_arvalid,
    output logic                    axi_arready,
    output logic                    axi_rvalid,
    output logic [31:0]             axi_rdata,
    input  logic                    axi_rready,
    // upstream sources
    input  src_beats_t              src_in,
    input  src_vec_t                src_valid,
    output src_vec_t                src_ready,
    // to serializer
    output axis_tagged_beat_t       is_out,
    output logic                    is_out_valid,
    input  logic                    is_out_ready,
    // from serializer
    input  axis_tagged_beat_t       is_in,
    input  logic                    is_in_valid,
    output logic                    is_in_ready,
    // downstream destinations
    output axis_beat_t              up_out,
    output logic                    up_out_valid,
    input  logic                    up_out_ready,
    output axis_beat_t              aa_out,
    output logic                    aa_out_valid,
    input  logic                    aa_out_ready
);

    // return fifo threshold
    th_t th;

    axis_sw_cfg_regs u_cfg_regs (
        .axis_clk     (axis_clk),
        .axi_reset_n  (axi_reset_n),
        .cc_as_enable (cc_as_enable),
        .axi_awvalid  (axi_awvalid),
        .axi_awaddr   (axi_awaddr),
        .axi_awready  (axi_awready),
        .axi_wvalid   (axi_wvalid),
        .axi_wdata    (axi_wdata),
        .axi_wstrb    (axi_wstrb),
        .axi_wready   (axi_wready),
        .axi_arvalid  (axi_arvalid),
        .axi_arready  (axi_arready),
        .axi_rvalid   (axi_rvalid),
        .axi_rdata    (axi_rdata),
        .axi_rready   (axi_rready),
        .th           (th)
    );

    axis_frame_arbiter u_arbiter (
        .axis_clk     (axis_clk),
        .axi_reset_n  (axi_reset_n),
        .src_in       (src_in),
        .src_valid    (src_valid),
        .src_ready    (src_ready),
        .is_out       (is_out),
        .is_out_valid (is_out_valid),
        .is_out_ready (is_out_ready)
    );

    axis_return_demux u_demux (
        .axis_clk     (axis_clk),
        .axi_reset_n  (axi_reset_n),
        .th           (th),
        .is_in        (is_in),
        .is_in_valid  (is_in_valid),
        .is_in_ready  (is_in_ready),
        .up_out       (up_out),
        .up_out_valid (up_out_valid),
        .up_out_ready (up_out_ready),
        .aa_out       (aa_out),
        .aa_out_valid (aa_out_valid),
        .aa_out_ready (aa_out_ready)
    );

endmodule

//--- sim/axis_sw_assertions.sv
module axis_sw_assertions
    import axis_sw_pkg::*;
(
    input logic              axis_clk,
    input logic              axi_reset_n,
    input src_vec_t          src_ready,
    input axis_tagged_beat_t is_out,
    input logic              is_out_valid,
    input logic              is_out_ready
);

    // grant is one-hot, so at most one source sees ready
    a_one_ready: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        $onehot0(src_ready))
        else $error("more than one src_ready bit high");

    // output register holds under back-pressure
    a_out_hold: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        is_out_valid && !is_out_ready |=> $stable(is_out))
        else $error("is_out changed while stalled");

    a_reset_idle: assert property (@(posedge axis_clk)
        $rose(axi_reset_n) |-> !is_out_valid)
        else $error("is_out_valid high in first cycle after reset");

endmodule

bind axis_frame_arbiter axis_sw_assertions u_assertions (.*);

//--- sim/axis_sw_tb.sv
`include "axis_sw_macros.svh"

module axis_sw_tb
    import axis_sw_pkg::*;
();

    localparam int CYCLE     = 100;
    localparam int NUM_TESTS = 6;

    logic                    axis_clk = 1'b0;
    logic                    axi_reset_n;
    logic                    cc_as_enable;
    logic                    axi_awvalid;
    logic [`AXIL_ADDR_W-1:0] axi_awaddr;
    logic                    axi_wvalid;
    logic [31:0]             axi_wdata;
    logic [3:0]              axi_wstrb;
    logic                    axi_arvalid;
    logic                    axi_rready;
    logic                    axi_awready;
    logic                    axi_wready;
    logic                    axi_arready;
    logic                    axi_rvalid;
    logic [31:0]             axi_rdata;
    src_beats_t              src_in = '0;
    src_vec_t                src_valid = '0;
    src_vec_t                src_ready;
    axis_tagged_beat_t       is_out;
    axis_tagged_beat_t       is_in;
    logic                    is_out_valid;
    logic                    is_out_ready;
    logic                    is_in_valid;
    logic                    is_in_ready;
    axis_beat_t              up_out;
    axis_beat_t              aa_out;
    logic                    up_out_valid;
    logic                    up_out_ready;
    logic                    aa_out_valid;
    logic                    aa_out_ready;

    logic [31:0]       rng_state = 32'heb09a026;
    int                error_count = 0;
    axis_beat_t        src_q [3][$];
    axis_tagged_beat_t exp_q[$];
    axis_tagged_beat_t got_q[$];
    axis_beat_t        up_exp[$];
    axis_beat_t        aa_exp[$];
    axis_beat_t        up_q[$];
    axis_beat_t        aa_q[$];

    axis_sw DUT (.*);

    always #(CYCLE/2) axis_clk = ~axis_clk;

    initial begin
        #(NUM_TESTS * 200 * CYCLE + 50 * CYCLE);
        abort_run("watchdog expired before the tests finished");
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic abort_run(input string why);
        error_count++;
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_beat(input string name, input axis_beat_t got, input axis_beat_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_tid(input string name, input axis_tid_t got, input axis_tid_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_th(input string name, input th_t got, input th_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic axis_beat_t random_beat(input logic last);
        axis_beat_t  b;
        logic [31:0] r;
        r      = next_rand();
        b.data = next_rand();
        b.strb = r[3:0];
        b.keep = r[7:4];
        b.last = last;
        b.user = r[9:8];
        return b;
    endfunction

    task automatic next_cycle();
        @(posedge axis_clk);
        #10;
    endtask

    // source driver pops on transfer and presents the next queued beat
    always @(posedge axis_clk) begin
        for (int s = 0; s < 3; s++) begin
            if (src_valid[s] && src_ready[s]) begin
                void'(src_q[s].pop_front());
            end
        end
        #10;
        for (int s = 0; s < 3; s++) begin
            src_valid[s] = (src_q[s].size() != 0);
            if (src_q[s].size() != 0) begin
                src_in[s] = src_q[s][0];
            end
        end
    end

    // transfer monitor on all outgoing streams
    always @(posedge axis_clk) begin
        if (is_out_valid && is_out_ready) begin
            got_q.push_back(is_out);
        end
        if (up_out_valid && up_out_ready) begin
            up_q.push_back(up_out);
        end
        if (aa_out_valid && aa_out_ready) begin
            aa_q.push_back(aa_out);
        end
    end

    //////////////////////////////
    // axi-lite access
    //////////////////////////////

    task automatic axil_write(input logic [14:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic en);
        cc_as_enable = en;
        axi_awvalid  = 1'b1;
        axi_wvalid   = 1'b1;
        axi_awaddr   = addr;
        axi_wdata    = data;
        axi_wstrb    = strb;
        repeat (en ? 1 : 3) begin
            @(posedge axis_clk);
            if (axi_awready !== en || axi_wready !== en) begin
                abort_run("awready/wready do not follow cc_as_enable");
            end
        end
        #10;
        axi_awvalid  = 1'b0;
        axi_wvalid   = 1'b0;
        cc_as_enable = 1'b1;
    endtask

    task automatic read_and_check(input th_t exp);
        logic [31:0] rdata;
        axi_arvalid = 1'b1;
        axi_rready  = 1'b1;
        @(posedge axis_clk);
        while (!axi_arready) begin
            @(posedge axis_clk);
        end
        #10;
        axi_arvalid = 1'b0;
        @(posedge axis_clk);
        if (!axi_rvalid) begin
            abort_run("rvalid did not rise one cycle after the read address transfer");
        end
        if (axi_arready) begin
            abort_run("arready stayed high while rvalid was high");
        end
        rdata = axi_rdata;
        #10;
        axi_rready = 1'b0;
        if (rdata[31:`TH_W] != '0) begin
            abort_run("read data has nonzero bits above the threshold field");
        end
        check_th("axi_rdata", rdata[`TH_W-1:0], exp);
    endtask

    //////////////////////////////
    // upstream path
    //////////////////////////////

    task automatic queue_frame(input int src, input int len);
        axis_tagged_beat_t t;
        for (int i = 0; i < len; i++) begin
            t.beat = random_beat(i == len - 1);
            t.tid  = axis_tid_t'(src);
            src_q[src].push_back(t.beat);
            exp_q.push_back(t);
        end
    endtask

    task automatic compare_upstream();
        axis_tagged_beat_t got;
        axis_tagged_beat_t exp;
        while (got_q.size() < exp_q.size()) begin
            next_cycle();
        end
        repeat (4) next_cycle();
        if (got_q.size() != exp_q.size()) begin
            abort_run("is_out carried more beats than the sources sent");
        end
        while (exp_q.size() != 0) begin
            got = got_q.pop_front();
            exp = exp_q.pop_front();
            check_beat("is_out.beat", got.beat, exp.beat);
            check_tid("is_out.tid", got.tid, exp.tid);
        end
    endtask

    //////////////////////////////
    // return path
    //////////////////////////////

    function automatic axis_tagged_beat_t make_return(input axis_tid_t tid);
        axis_tagged_beat_t t;
        logic [31:0]       r;
        r      = next_rand();
        t.beat = random_beat(r[0]);
        t.tid  = tid;
        return t;
    endfunction

    // tid 2 and 3 have no destination
    function automatic void expect_return(input axis_tagged_beat_t t);
        if (t.tid == TID_UP) begin
            up_exp.push_back(t.beat);
        end else if (t.tid == TID_AA) begin
            aa_exp.push_back(t.beat);
        end
    endfunction

    task automatic send_return(input axis_tagged_beat_t t);
        is_in       = t;
        is_in_valid = 1'b1;
        @(posedge axis_clk);
        while (!is_in_ready) begin
            @(posedge axis_clk);
        end
        expect_return(t);
        #10;
        is_in_valid = 1'b0;
    endtask

    task automatic compare_returns();
        axis_beat_t got;
        axis_beat_t exp;
        while (up_q.size() < up_exp.size() || aa_q.size() < aa_exp.size()) begin
            next_cycle();
        end
        repeat (4) next_cycle();
        if (up_q.size() != up_exp.size() || aa_q.size() != aa_exp.size()) begin
            abort_run("a return destination received beats that were not its own");
        end
        while (up_exp.size() != 0) begin
            got = up_q.pop_front();
            exp = up_exp.pop_front();
            check_beat("up_out", got, exp);
        end
        while (aa_exp.size() != 0) begin
            got = aa_q.pop_front();
            exp = aa_exp.pop_front();
            check_beat("aa_out", got, exp);
        end
    endtask

    // offer beats until is_in_ready stays low and then drain
    task automatic flood_returns(input th_t th_val);
        axis_tagged_beat_t cur;
        logic [31:0]       r;
        int                accepted;
        int                idle;
        accepted     = 0;
        idle         = 0;
        up_out_ready = 1'b0;
        aa_out_ready = 1'b0;
        r            = next_rand();
        cur          = make_return(axis_tid_t'(r[0]));
        is_in        = cur;
        is_in_valid  = 1'b1;
        while (idle < 8) begin
            @(posedge axis_clk);
            if (is_in_ready) begin
                expect_return(cur);
                accepted++;
                idle = 0;
                r    = next_rand();
                cur  = make_return(axis_tid_t'(r[0]));
            end else begin
                idle++;
            end
            #10;
            is_in = cur;
        end
        is_in_valid = 1'b0;
        if (accepted < int'(th_val) + 1 || accepted > int'(th_val) + 2) begin
            abort_run($sformatf("FIFO accepted %0d beats with threshold %0d", accepted, th_val));
        end
        up_out_ready = 1'b1;
        aa_out_ready = 1'b1;
        compare_returns();
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic test_registers();
        read_and_check(th_t'(`TH_RESET));
        axil_write(15'h0, 32'h9, 4'hf, 1'b1);
        read_and_check(4'd9);
        axil_write(15'h0, 32'h5, 4'he, 1'b1);
        axil_write(15'h4, 32'h5, 4'hf, 1'b1);
        axil_write(15'h0, 32'h5, 4'hf, 1'b0);
        read_and_check(4'd9);
        axil_write(15'h0, 32'(`TH_RESET), 4'h1, 1'b1);
    endtask

    task automatic test_single_frames();
        for (int s = 0; s < 3; s++) begin
            @(posedge axis_clk);
            queue_frame(s, 4);
            compare_upstream();
        end
    endtask

    task automatic test_round_robin();
        @(posedge axis_clk);
        queue_frame(0, 3);
        queue_frame(1, 3);
        queue_frame(2, 3);
        compare_upstream();
        // search restarts after source 2
        @(posedge axis_clk);
        queue_frame(0, 3);
        queue_frame(2, 3);
        compare_upstream();
    endtask

    task automatic test_backpressure();
        logic [31:0] r;
        @(posedge axis_clk);
        queue_frame(0, 3);
        queue_frame(1, 3);
        queue_frame(0, 3);
        queue_frame(1, 3);
        while (got_q.size() < exp_q.size()) begin
            next_cycle();
            r            = next_rand();
            is_out_ready = r[0];
        end
        is_out_ready = 1'b1;
        compare_upstream();
    endtask

    task automatic test_return_routing();
        axis_tagged_beat_t t;
        for (int i = 0; i < 9; i++) begin
            t = make_return(axis_tid_t'(i % 3));
            send_return(t);
        end
        compare_returns();
        // stalled tid 0 head blocks the tid 1 beat behind it
        up_out_ready = 1'b0;
        send_return(make_return(TID_UP));
        send_return(make_return(TID_AA));
        repeat (6) begin
            @(posedge axis_clk);
            if (aa_out_valid || !up_out_valid) begin
                abort_run("aa_out_valid rose while a tid 0 head was stalled");
            end
        end
        #10;
        up_out_ready = 1'b1;
        compare_returns();
    endtask

    task automatic test_threshold();
        flood_returns(th_t'(`TH_RESET));
        axil_write(15'h0, 32'h2, 4'hf, 1'b1);
        read_and_check(4'd2);
        flood_returns(4'd2);
    endtask

    initial begin
        axi_reset_n  = 1'b0;
        cc_as_enable = 1'b1;
        axi_awvalid  = 1'b0;
        axi_awaddr   = '0;
        axi_wvalid   = 1'b0;
        axi_wdata    = '0;
        axi_wstrb    = '0;
        axi_arvalid  = 1'b0;
        axi_rready   = 1'b0;
        is_out_ready = 1'b1;
        is_in        = '0;
        is_in_valid  = 1'b0;
        up_out_ready = 1'b1;
        aa_out_ready = 1'b1;
        repeat (3) @(posedge axis_clk);
        #10;
        axi_reset_n = 1'b1;
        test_registers();
        test_single_frames();
        test_round_robin();
        test_backpressure();
        test_return_routing();
        test_threshold();
        if (error_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "errors found");
        end
    end

endmodule

//--- files.f
+incdir+include
hdl/axis_sw_pkg.sv
hdl/axis_sw_cfg_regs.sv
hdl/axis_frame_arbiter.sv
hdl/axis_return_demux.sv
hdl/axis_sw.sv
sim/axis_sw_assertions.sv
sim/axis_sw_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the axis_sw testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module axis_sw_tb \
    -f files.f -o axis_sw_sim \
    && ./obj_dir/axis_sw_sim | tee /dev/stderr | grep -qx "sim passed" \
    && echo "simulation OK" \
    || { echo "simulation FAILED"; exit 1; }
